// File: Makefile
VERILATOR ?= verilator
TOP       ?= da_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/da_pkg.sv
`default_nettype none

package da_pkg;

    // ======================================================================
    // sizes
    // ======================================================================
    localparam int n_in      = 12;  // select bits and weights.
    localparam int lut_bits  = 4;   // select bits per group.
    localparam int n_groups  = 3;
    localparam int lut_depth = 16;  // entries per group table.

    localparam int w_width   = 16;
    localparam int acc_width = 24;  // wide enough for twelve full-scale weights.

    typedef logic signed [w_width-1:0]   weight_t;
    typedef logic signed [acc_width-1:0] acc_t;

    // ======================================================================
    // register map
    // ======================================================================
    // weight k lives at addr_weight0 + 4*k.
    localparam logic [7:0] addr_weight0 = 8'h00;
    localparam logic [7:0] addr_ctrl    = 8'h30;  // bit 0 starts a rebuild.
    localparam logic [7:0] addr_status  = 8'h34;  // bit 0 busy, bit 1 tables valid.

endpackage

`default_nettype wire

// File: common/lut_fill_if.sv
`timescale 1ns/1ps
`default_nettype none

// table rebuild commands from the control block to the LUT bank.
interface lut_fill_if;
    import da_pkg::*;

    logic                fill_en;     // write one entry per group this cycle.
    logic [lut_bits-1:0] fill_index;  // entry being written.
    weight_t             weights [n_in];

    modport ctrl (
        output fill_en,
        output fill_index,
        output weights
    );

    modport bank (
        input fill_en,
        input fill_index,
        input weights
    );

endinterface

`default_nettype wire

// File: dv/da_input.txt
# W addr data: write, E addr data: write that must error, R addr expected: read check
# S: rebuild and poll, Q sel: query, N count: random queries; hex except the N count
R 34 00000000
Q fff
Q 123
W 00 00001234
W 04 0000fedc
W 08 00007fff
W 0c 00008000
W 10 00000101
W 14 0000ff00
W 18 00000033
W 1c 0000ffff
W 20 00000200
W 24 00004000
W 28 0000c000
W 2c 00000007
R 04 fffffedc
R 0c ffff8000
R 08 00007fff
S
R 34 00000002
Q fff
Q 000
Q a5c
Q 3c3
Q 801
W 30 00000001
E 00 00005555
E 30 00000001
R 00 00001234
Q 5a5
E 40 00000000
E 02 00000000
W 00 0000abcd
W 14 00000555
W 28 00007000
S
R 00 ffffabcd
N 100

// File: dv/da_tb.sv
`timescale 1ns/1ps
`default_nettype none

module da_tb;
    import da_pkg::*;

    logic            clk;
    logic            rst_n;
    logic [7:0]      paddr;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [31:0]     pwdata;
    logic [31:0]     prdata;
    logic            pready;
    logic            pslverr;
    logic            sel_valid;
    logic [n_in-1:0] sel;
    logic            sel_ready;
    logic            result_valid;
    acc_t            result;

    weight_t     wreg [n_in];  // register copy.
    weight_t     wtab [n_in];  // weights the tables were last built from.
    logic [31:0] pred_q [$];
    int          acc_q [$];    // acceptance edge of each pending query.
    byte         cmd_q [$];
    int          arg_a_q [$];
    logic [31:0] arg_d_q [$];
    int          cycle = 0;
    int          timeout_cycles = 0;
    int          mismatches = 0;
    int          failures = 0;
    integer      seed = 72696;

    tb_clk_gen #(.period(10)) u_clk (.clk(clk));

    da_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .sel_valid    (sel_valid),
        .sel          (sel),
        .sel_ready    (sel_ready),
        .result_valid (result_valid),
        .result       (result)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    // each bit weighs in as +1 when set, -1 when clear.
    function automatic logic [31:0] predict(input logic [n_in-1:0] s);
        int sum;
        sum = 0;
        for (int i = 0; i < n_in; i++) begin
            if (s[i]) begin
                sum = sum + int'(wtab[i]);
            end else begin
                sum = sum - int'(wtab[i]);
            end
        end
        return 32'(sum);
    endfunction

    // ======================================================================
    // drivers
    // ======================================================================
    task automatic apb_access(input logic [7:0] a, input logic [31:0] d, input logic wr,
                              output logic [31:0] rd, output logic err);
        @(negedge clk);
        sel_valid = 1'b0;
        paddr     = a;
        pwdata    = d;
        pwrite    = wr;
        psel      = 1'b1;
        penable   = 1'b0;
        @(negedge clk);
        penable = 1'b1;  // access phase, completes on the next rising edge.
        #1;  // let the response settle.
        rd      = prdata;
        err     = pslverr;
        check({31'b0, pready}, 32'd1, "pready in access phase");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_weight_or_ctrl(input logic [7:0] a, input logic [31:0] d);
        logic [31:0] rd;
        logic        err;
        apb_access(a, d, 1'b1, rd, err);
        check({31'b0, err}, 32'd0, $sformatf("pslverr on write to %h", a));
        if (a < 8'(4 * n_in) && a[1:0] == 2'b00) begin
            wreg[a[5:2]] = d[w_width-1:0];
        end else if (a == addr_ctrl && d[0]) begin
            for (int i = 0; i < n_in; i++) begin
                wtab[i] = wreg[i];
            end
            check({31'b0, sel_ready}, 32'd0, "sel_ready during rebuild");
        end
    endtask

    task automatic start_rebuild();
        logic [31:0] rd;
        logic        err;
        logic        done;
        write_weight_or_ctrl(addr_ctrl, 32'd1);
        done = 1'b0;
        for (int p = 0; p < 40 && !done; p++) begin
            apb_access(addr_status, 32'd0, 1'b0, rd, err);
            done = !rd[0];
        end
        if (!done) begin
            failures++;
            $display("status polling never saw busy clear after a rebuild start");
        end
    endtask

    task automatic do_query(input logic [n_in-1:0] s);
        @(negedge clk);
        sel_valid = 1'b1;
        sel       = s;
        while (!sel_ready) begin
            @(negedge clk);  // held until the rebuild is over.
        end
        pred_q.push_back(predict(s));
        acc_q.push_back(cycle + 1);
    endtask

    // results are stable between the rising edge and the falling one.
    always @(negedge clk) begin
        if (result_valid === 1'b1) begin
            if (pred_q.size() == 0) begin
                failures++;
                $display("a result %h arrived at %0t ns with no query pending", result, $time);
            end else begin
                check({{8{result[acc_width-1]}}, result}, pred_q.pop_front(), "query result");
                check(32'(cycle), 32'(acc_q.pop_front() + 3), "result latency");
            end
        end
    end

    // ======================================================================
    // command file
    // ======================================================================
    task automatic load_commands(output logic ok);
        int          fd;
        int          nrand;
        int          a;
        logic [31:0] d;
        string       line;
        string       rest;
        byte         c;
        ok    = 1'b0;
        nrand = 0;
        fd    = $fopen("dv/da_input.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    c    = line[0];
                    a    = 0;
                    d    = '0;
                    rest = line.substr(1, line.len() - 1);
                    if (c == "N") begin
                        void'($sscanf(rest, "%d", a));
                        nrand = nrand + a;
                    end else begin
                        void'($sscanf(rest, "%h %h", a, d));
                    end
                    cmd_q.push_back(c);
                    arg_a_q.push_back(a);
                    arg_d_q.push_back(d);
                end
            end
            $fclose(fd);
            ok = (cmd_q.size() > 0);
            timeout_cycles = 50 + 100 * cmd_q.size() + 10 * nrand;
        end
    endtask

    task automatic run_commands();
        logic [31:0] rd;
        logic        err;
        int          a;
        logic [31:0] d;
        for (int i = 0; i < cmd_q.size(); i++) begin
            a = arg_a_q[i];
            d = arg_d_q[i];
            case (cmd_q[i])
                "W": write_weight_or_ctrl(a[7:0], d);
                "E": begin
                    apb_access(a[7:0], d, 1'b1, rd, err);
                    check({31'b0, err}, 32'd1, $sformatf("pslverr on write to %h", a[7:0]));
                end
                "R": begin
                    apb_access(a[7:0], 32'd0, 1'b0, rd, err);
                    check(rd, d, $sformatf("read of %h", a[7:0]));
                    check({31'b0, err}, 32'd0, $sformatf("pslverr on read of %h", a[7:0]));
                end
                "S": start_rebuild();
                "Q": do_query(a[n_in-1:0]);
                "N": begin
                    for (int k = 0; k < a; k++) begin
                        do_query(n_in'($random(seed)));
                    end
                end
                default: begin
                    failures++;
                    $display("unknown command in entry %0d of the command file", i + 1);
                end
            endcase
        end
    endtask

    task automatic drain();
        int waited;
        @(negedge clk);
        sel_valid = 1'b0;
        waited    = 0;
        while (pred_q.size() > 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (pred_q.size() > 0) begin
            failures++;
            $display("%0d query results never arrived", pred_q.size());
        end
    endtask

    task automatic report();
        $display("checks done: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        logic loaded;
        rst_n     = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        sel_valid = 1'b0;
        sel       = '0;
        for (int i = 0; i < n_in; i++) begin
            wreg[i] = '0;
            wtab[i] = '0;
        end
        load_commands(loaded);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        if (!loaded) begin
            failures++;
            $display("could not read any command from dv/da_input.txt");
        end else begin
            run_commands();
            drain();
        end
        report();
    end

    // watchdog.
    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles and the run was stopped", timeout_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int period = 10  // ns.
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: hdl/adder_tree.sv
`timescale 1ns/1ps
`default_nettype none

module adder_tree (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  da_pkg::acc_t in_data [da_pkg::n_groups],
    output logic         out_valid,
    output da_pkg::acc_t out_data
);
    import da_pkg::*;

    acc_t sum01_q;  // layer 1, groups 0 and 1.
    acc_t pass2_q;  // layer 1, group 2 alone.
    logic l1_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            l1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            l1_valid  <= in_valid;
            out_valid <= l1_valid;
        end
    end

    // ======================================================================
    // datapath
    // ======================================================================
    always_ff @(posedge clk) begin
        if (in_valid) begin
            sum01_q <= in_data[0] + in_data[1];
            pass2_q <= in_data[2];
        end
    end

    always_ff @(posedge clk) begin
        if (l1_valid) begin
            out_data <= sum01_q + pass2_q;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(out_valid)
    );

endmodule

`default_nettype wire

// File: hdl/da_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module da_ctrl (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        sel_ready,
    lut_fill_if.ctrl    fill
);
    import da_pkg::*;

    weight_t             weights [n_in];
    logic                busy;
    logic                tables_valid;
    logic [lut_bits-1:0] fill_cnt;

    logic                access;
    logic [7:0]          woff;
    logic [lut_bits-1:0] widx;
    logic                hit_weight;
    logic                hit_ctrl;
    logic                hit_status;
    logic                bad_addr;
    logic                bad_busy;
    logic                wr_ok;
    logic                start;

    // ======================================================================
    // APB decode
    // ======================================================================
    assign access     = psel && penable;
    assign woff       = paddr - addr_weight0;
    assign widx       = woff[5:2];
    assign hit_weight = (woff < 8'(n_in * 4)) && (woff[1:0] == 2'b00);
    assign hit_ctrl   = (paddr == addr_ctrl);
    assign hit_status = (paddr == addr_status);

    assign bad_addr = !(hit_weight || hit_ctrl || hit_status);
    // tables are being rebuilt from the weights, so hold them steady.
    assign bad_busy = busy && pwrite && (hit_weight || (hit_ctrl && pwdata[0]));

    assign pready  = 1'b1;  // zero wait states.
    assign pslverr = access && (bad_addr || bad_busy);
    assign wr_ok   = access && pwrite && !bad_addr && !bad_busy;
    assign start   = wr_ok && hit_ctrl && pwdata[0];

    always_comb begin
        prdata = '0;
        if (hit_weight) begin
            prdata = 32'(weights[widx]);  // sign extended.
        end else if (hit_status) begin
            prdata = {30'b0, tables_valid, busy};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < n_in; i++) begin
                weights[i] <= '0;
            end
        end else if (wr_ok && hit_weight) begin
            weights[widx] <= pwdata[w_width-1:0];
        end
    end

    // ======================================================================
    // rebuild sequencer
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            tables_valid <= 1'b0;
            fill_cnt     <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            fill_cnt <= '0;
        end else if (busy) begin
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt == lut_bits'(lut_depth - 1)) begin
                busy         <= 1'b0;  // last entry written this cycle.
                tables_valid <= 1'b1;
            end
        end
    end

    assign fill.fill_en    = busy;
    assign fill.fill_index = fill_cnt;
    assign fill.weights    = weights;
    assign sel_ready       = !busy;  // no queries against half-built tables.

    // a rebuild stops after its last entry and is never restarted midway.
    a_fill_ends: assert property (
        @(posedge clk) disable iff (!rst_n)
            fill.fill_en && (fill.fill_index == lut_bits'(lut_depth - 1)) |=> !fill.fill_en
    );

endmodule

`default_nettype wire

// File: hdl/da_top.sv
`timescale 1ns/1ps
`default_nettype none

module da_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    sel_valid,
    input  logic [da_pkg::n_in-1:0] sel,
    output logic                    sel_ready,
    output logic                    result_valid,
    output da_pkg::acc_t            result
);
    import da_pkg::*;

    logic accept;
    logic lut_valid;
    acc_t lut_out [n_groups];

    lut_fill_if fill_bus ();

    assign accept = sel_valid && sel_ready;  // handshake resolved once here.

    da_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .sel_ready (sel_ready),
        .fill      (fill_bus.ctrl)
    );

    lut_bank u_lut (
        .clk       (clk),
        .rst_n     (rst_n),
        .fill      (fill_bus.bank),
        .sel_valid (accept),
        .sel       (sel),
        .lut_valid (lut_valid),
        .lut_out   (lut_out)
    );

    adder_tree u_tree (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (lut_valid),
        .in_data   (lut_out),
        .out_valid (result_valid),
        .out_data  (result)
    );

endmodule

`default_nettype wire

// File: lut/lut_bank.sv
`timescale 1ns/1ps
`default_nettype none

module lut_bank (
    input  logic                    clk,
    input  logic                    rst_n,
    lut_fill_if.bank                fill,
    input  logic                    sel_valid,
    input  logic [da_pkg::n_in-1:0] sel,
    output logic                    lut_valid,
    output da_pkg::acc_t            lut_out [da_pkg::n_groups]
);
    import da_pkg::*;

    logic [n_in-1:0] sel_q;
    logic            sel_q_valid;

    // accepted query is captured first, table read on the next edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q_valid <= 1'b0;
            lut_valid   <= 1'b0;
        end else begin
            sel_q_valid <= sel_valid;
            lut_valid   <= sel_q_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            sel_q <= sel;
        end
    end

    // ======================================================================
    // group tables
    // ======================================================================
    generate
        for (genvar g = 0; g < n_groups; g++) begin : g_group
            acc_t table_mem [lut_depth];
            acc_t entry;
            acc_t rd_q;

            // signed sum of the group's weights for the entry being filled.
            always_comb begin
                entry = '0;
                for (int j = 0; j < lut_bits; j++) begin
                    if (fill.fill_index[j]) begin
                        entry = entry + acc_t'(fill.weights[g*lut_bits + j]);
                    end else begin
                        entry = entry - acc_t'(fill.weights[g*lut_bits + j]);
                    end
                end
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < lut_depth; i++) begin
                        table_mem[i] <= '0;  // all-zero weights give zero entries.
                    end
                end else if (fill.fill_en) begin
                    table_mem[fill.fill_index] <= entry;
                end
            end

            always_ff @(posedge clk) begin
                if (sel_q_valid) begin
                    rd_q <= table_mem[sel_q[g*lut_bits +: lut_bits]];
                end
            end

            assign lut_out[g] = rd_q;
        end
    endgenerate

endmodule

`default_nettype wire

// File: src.f
common/da_pkg.sv
common/lut_fill_if.sv
hdl/da_ctrl.sv
lut/lut_bank.sv
hdl/adder_tree.sv
hdl/da_top.sv
dv/tb_clk_gen.sv
dv/da_tb.sv
